//--- mips_id_config.svh
`ifndef MIPS_ID_CONFIG_SVH
`define MIPS_ID_CONFIG_SVH

// primary opcodes
`define MIPS_OP_RTYPE   6'b000000
`define MIPS_OP_J       6'b000010
`define MIPS_OP_JAL     6'b000011
`define MIPS_OP_BEQ     6'b000100
`define MIPS_OP_BNE     6'b000101

// opcode[5:3] groups
`define MIPS_GRP_IMM    3'b001
`define MIPS_GRP_LOAD   3'b100
`define MIPS_GRP_STORE  3'b101

// r-type funct codes
`define MIPS_FN_JR      6'b001000
`define MIPS_FN_JALR    6'b001001

// special instruction words
`define MIPS_NOP_WORD   32'h0000_0000
`define MIPS_HALT_WORD  32'hffff_ffff

`define MIPS_LINK_REG   5'd31 // return address register

`endif

//--- mips_id_pkg.sv
`default_nettype none

package mips_id_pkg;

    // one fetched word, read in three formats
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_t;

    typedef struct packed {
        logic mem_to_reg; // 1 alu result, 0 memory
        logic reg_write;
    } wb_ctl_t;

    typedef struct packed {
        logic       mem_read;
        logic       mem_write;
        logic       is_unsigned;
        logic [1:0] data_width; // 00 byte, 01 half, 11 word
    } mem_ctl_t;

    typedef struct packed {
        logic       reg_dest; // 1 selects rd
        logic [1:0] alu_op;   // 00 add, 01 cmp, 10 funct, 11 imm logic
        logic       alu_src;  // 1 selects immediate
    } ex_ctl_t;

    typedef struct packed {
        wb_ctl_t  wb;
        mem_ctl_t mem;
        ex_ctl_t  ex;
    } id_ctl_t;

    // operands and fields handed to EX
    typedef struct packed {
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] imm;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  opcode;
        logic [5:0]  funct;
    } id_ex_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
        logic [1:0]  reg_use; // 00 none, 01 rs and rt, 10 rs only
    } jump_t;

endpackage

`default_nettype wire

//--- id_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_id_config.svh"

module id_control_unit
    import mips_id_pkg::*;
(
    input  wire     i_clk,
    input  wire     i_reset,
    input  instr_t  i_instr,
    input  wire     i_stall,
    input  wire     i_halt,
    output id_ctl_t o_ctl,
    output logic    o_ld_en
);

    id_ctl_t decoded;
    id_ctl_t ctl_next;
    logic    bubble;

    // class decode of one instruction word into the full control bundle
    function automatic id_ctl_t decode_ctl(input instr_t instr);
        id_ctl_t    ctl;
        logic [5:0] op;
        logic [5:0] fn;
        ctl = '0;
        op  = instr.r_fmt.opcode;
        fn  = instr.r_fmt.funct;
        ctl.wb.mem_to_reg = 1'b1; // alu result unless a load

        if (op == `MIPS_OP_RTYPE) begin
            ctl.wb.reg_write = (fn != `MIPS_FN_JR); // jr has no result
            ctl.ex.reg_dest  = 1'b1;
            ctl.ex.alu_src   = 1'b0;
            if (fn == `MIPS_FN_JALR) begin
                ctl.ex.alu_op = 2'b00; // pc + 4 into rd
            end else begin
                ctl.ex.alu_op = 2'b10;
            end
        end else if (op[5:3] == `MIPS_GRP_LOAD) begin
            ctl.wb.mem_to_reg     = 1'b0;
            ctl.wb.reg_write      = 1'b1;
            ctl.mem.mem_read      = 1'b1;
            ctl.mem.is_unsigned   = op[2];
            ctl.mem.data_width    = op[1:0];
            ctl.ex.alu_op         = 2'b00; // base + offset
            ctl.ex.alu_src        = 1'b1;
        end else if (op[5:3] == `MIPS_GRP_STORE) begin
            ctl.mem.mem_write     = 1'b1;
            ctl.mem.is_unsigned   = op[2];
            ctl.mem.data_width    = op[1:0];
            ctl.ex.alu_op         = 2'b00;
            ctl.ex.alu_src        = 1'b1;
        end else if (op[5:3] == `MIPS_GRP_IMM) begin
            ctl.wb.reg_write      = 1'b1;
            ctl.ex.alu_op         = 2'b11;
            ctl.ex.alu_src        = 1'b1; // result lands in rt
        end else if (op == `MIPS_OP_JAL) begin
            // operands are already pc and 4 and the destination is forced to rd = 31
            ctl.wb.reg_write      = 1'b1;
            ctl.ex.reg_dest       = 1'b1;
            ctl.ex.alu_op         = 2'b00;
        end else if (op == `MIPS_OP_BEQ || op == `MIPS_OP_BNE) begin
            ctl.ex.alu_op         = 2'b01; // compare ra and rb
        end
        return ctl;
    endfunction

    always_comb begin
        decoded  = decode_ctl(i_instr);
        bubble   = i_stall || (i_instr == `MIPS_NOP_WORD);
        ctl_next = bubble ? id_ctl_t'('0) : decoded;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ctl <= '0;
        end else if (!i_halt) begin
            o_ctl <= ctl_next; // halt holds the bundle
        end
    end

    assign o_ld_en = ~i_halt; // operand register follows the same freeze

endmodule

`default_nettype wire

//--- register_bank.sv
`timescale 1ns/1ps
`default_nettype none

module register_bank (
    input  wire         i_clk,
    input  wire         i_reset,
    input  wire         i_we,
    input  wire  [4:0]  i_waddr,
    input  wire  [31:0] i_wdata,
    input  wire  [4:0]  i_raddr_a,
    input  wire  [4:0]  i_raddr_b,
    output logic [31:0] o_rdata_a,
    output logic [31:0] o_rdata_b
);

    logic [31:0] regs [32];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != 5'd0)) begin
            regs[i_waddr] <= i_wdata; // r0 never written
        end
    end

    // asynchronous reads so a same-cycle write shows up next cycle
    always_comb begin
        if (i_raddr_a == 5'd0) begin
            o_rdata_a = '0;
        end else begin
            o_rdata_a = regs[i_raddr_a];
        end

        if (i_raddr_b == 5'd0) begin
            o_rdata_b = '0;
        end else begin
            o_rdata_b = regs[i_raddr_b];
        end
    end

endmodule

`default_nettype wire

//--- branch_resolver.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_id_config.svh"

module branch_resolver
    import mips_id_pkg::*;
(
    input  instr_t      i_instr,
    input  wire  [31:0] i_pc,
    input  wire  [31:0] i_ra,
    input  wire  [31:0] i_rb,
    output jump_t       o_jump
);

    logic [31:0] imm_ext;
    logic [31:0] branch_target;
    logic [31:0] region_target;
    logic [5:0]  funct;

    assign imm_ext       = {{16{i_instr.i_fmt.imm16[15]}}, i_instr.i_fmt.imm16};
    assign branch_target = i_pc + 32'd4 + (imm_ext << 2); // relative to delay slot pc
    assign region_target = {i_pc[31:28], i_instr.j_fmt.target26, 2'b00};
    assign funct         = i_instr.r_fmt.funct;

    always_comb begin
        o_jump = '0;

        case (i_instr.j_fmt.opcode)
            `MIPS_OP_BEQ: begin
                o_jump.reg_use = 2'b01;
                o_jump.taken   = (i_ra == i_rb);
                o_jump.target  = (i_ra == i_rb) ? branch_target : 32'd0;
            end
            `MIPS_OP_BNE: begin
                o_jump.reg_use = 2'b01;
                o_jump.taken   = (i_ra != i_rb);
                o_jump.target  = (i_ra != i_rb) ? branch_target : 32'd0;
            end
            `MIPS_OP_J, `MIPS_OP_JAL: begin
                o_jump.taken  = 1'b1;
                o_jump.target = region_target;
            end
            `MIPS_OP_RTYPE: begin
                if (funct == `MIPS_FN_JR || funct == `MIPS_FN_JALR) begin
                    o_jump.taken   = 1'b1;
                    o_jump.target  = i_ra; // register indirect
                    o_jump.reg_use = 2'b10;
                end
            end
            default: begin
                o_jump = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- operand_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_id_config.svh"

module operand_select
    import mips_id_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_reset,
    input  wire         i_ld_en,
    input  instr_t      i_instr,
    input  wire  [31:0] i_pc,
    input  wire  [31:0] i_ra,
    input  wire  [31:0] i_rb,
    output id_ex_t      o_ex
);

    id_ex_t ex_next;
    logic   is_jal;
    logic   is_jalr;

    assign is_jal  = (i_instr.j_fmt.opcode == `MIPS_OP_JAL);
    assign is_jalr = (i_instr.r_fmt.opcode == `MIPS_OP_RTYPE)
                  && (i_instr.r_fmt.funct == `MIPS_FN_JALR);

    always_comb begin
        ex_next.rs     = i_instr.r_fmt.rs;
        ex_next.shamt  = i_instr.r_fmt.shamt;
        ex_next.opcode = i_instr.r_fmt.opcode;
        ex_next.funct  = i_instr.r_fmt.funct;
        ex_next.imm    = {{16{i_instr.i_fmt.imm16[15]}}, i_instr.i_fmt.imm16};

        if (is_jal || is_jalr) begin
            // link value pc + 4 is built by the alu from these
            ex_next.ra = i_pc;
            ex_next.rb = 32'd4;
            ex_next.rt = 5'd0;
        end else begin
            ex_next.ra = i_ra;
            ex_next.rb = i_rb;
            ex_next.rt = i_instr.r_fmt.rt;
        end

        ex_next.rd = is_jal ? `MIPS_LINK_REG : i_instr.r_fmt.rd;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ex <= '0;
        end else if (i_ld_en) begin
            o_ex <= ex_next;
        end
    end

endmodule

`default_nettype wire

//--- instruction_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_id_config.svh"

module instruction_decode
    import mips_id_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_reset,
    input  instr_t      i_instr,
    input  wire  [31:0] i_pc,
    input  wire         i_wb_write,
    input  wire  [4:0]  i_wb_addr,
    input  wire  [31:0] i_wb_data,
    input  wire         i_stall,
    input  wire         i_halt,
    output id_ctl_t     o_ctl,
    output id_ex_t      o_ex,
    output jump_t       o_jump,
    output wire         o_halt
);

    wire [31:0] rd_a;
    wire [31:0] rd_b;
    wire        ld_en;

    assign o_halt = (i_instr == `MIPS_HALT_WORD); // all-ones word stops the core

    id_control_unit u_control (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_instr (i_instr),
        .i_stall (i_stall),
        .i_halt  (i_halt),
        .o_ctl   (o_ctl),
        .o_ld_en (ld_en)
    );

    register_bank u_regs (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_we      (i_wb_write),
        .i_waddr   (i_wb_addr),
        .i_wdata   (i_wb_data),
        .i_raddr_a (i_instr.r_fmt.rs),
        .i_raddr_b (i_instr.r_fmt.rt),
        .o_rdata_a (rd_a),
        .o_rdata_b (rd_b)
    );

    branch_resolver u_branch (
        .i_instr (i_instr),
        .i_pc    (i_pc),
        .i_ra    (rd_a),
        .i_rb    (rd_b),
        .o_jump  (o_jump)
    );

    operand_select u_operands (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_ld_en (ld_en),
        .i_instr (i_instr),
        .i_pc    (i_pc),
        .i_ra    (rd_a),
        .i_rb    (rd_b),
        .o_ex    (o_ex)
    );

endmodule

`default_nettype wire

//--- instruction_decode_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_id_config.svh"

module instruction_decode_asserts
    import mips_id_pkg::*;
(
    input wire         i_clk,
    input wire         i_reset,
    input instr_t      i_instr,
    input wire  [31:0] i_pc,
    input wire         i_stall,
    input wire         i_halt,
    input id_ctl_t     o_ctl,
    input id_ex_t      o_ex,
    input jump_t       o_jump,
    input wire         o_halt,
    input wire  [31:0] i_rd_a,
    input wire  [31:0] i_rd_b
);

    int fail_count = 0;

    logic [5:0] op;
    logic [5:0] fn;
    assign op = i_instr.r_fmt.opcode;
    assign fn = i_instr.r_fmt.funct;

    // bundle layout {wb(2), mem(5), ex(4)}
    function automatic logic [10:0] expected_ctl(input logic [31:0] w, input logic stall);
        logic [5:0] o;
        logic [5:0] f;
        o = w[31:26];
        f = w[5:0];
        if (stall || w == `MIPS_NOP_WORD) return 11'd0;
        if (o == `MIPS_OP_RTYPE) begin
            return {1'b1, f != `MIPS_FN_JR, 5'b0, 1'b1,
                    (f == `MIPS_FN_JALR) ? 2'b00 : 2'b10, 1'b0};
        end
        if (o[5:3] == `MIPS_GRP_LOAD) return {2'b01, 2'b10, o[2:0], 4'b0001};
        if (o[5:3] == `MIPS_GRP_STORE) return {2'b10, 2'b01, o[2:0], 4'b0001};
        if (o[5:3] == `MIPS_GRP_IMM) return {2'b11, 5'b0, 4'b0111};
        if (o == `MIPS_OP_JAL) return {2'b11, 5'b0, 4'b1000};
        if (o == `MIPS_OP_BEQ || o == `MIPS_OP_BNE) return {2'b10, 5'b0, 4'b0010};
        return {2'b10, 9'b0};
    endfunction

    a_ctl_decode: assert property (@(posedge i_clk) disable iff (i_reset)
        (!$past(i_reset) && !$past(i_halt))
        |-> (o_ctl == expected_ctl($past(i_instr), $past(i_stall))))
        else begin
            $error("control bundle differs from decode rules");
            fail_count++;
        end

    a_freeze: assert property (@(posedge i_clk) disable iff (i_reset)
        (!$past(i_reset) && $past(i_halt)) |-> ($stable(o_ctl) && $stable(o_ex)))
        else begin
            $error("halt did not hold the id/ex register");
            fail_count++;
        end

    a_ex_loads: assert property (@(posedge i_clk) disable iff (i_reset)
        (!$past(i_reset) && !$past(i_halt))
        |-> (o_ex.rs == $past(i_instr.r_fmt.rs) && o_ex.shamt == $past(i_instr.r_fmt.shamt)
             && o_ex.opcode == $past(op) && o_ex.funct == $past(fn)
             && o_ex.imm == {{16{$past(i_instr[15])}}, $past(i_instr[15:0])}))
        else begin
            $error("operand register did not load");
            fail_count++;
        end

    a_region_jump: assert property (@(posedge i_clk) disable iff (i_reset)
        (op == `MIPS_OP_J || op == `MIPS_OP_JAL)
        |-> (o_jump.taken && o_jump.target == {i_pc[31:28], i_instr.j_fmt.target26, 2'b00}
             && o_jump.reg_use == 2'b00))
        else begin
            $error("region jump target wrong");
            fail_count++;
        end

    a_reg_jump: assert property (@(posedge i_clk) disable iff (i_reset)
        (op == `MIPS_OP_RTYPE && (fn == `MIPS_FN_JR || fn == `MIPS_FN_JALR))
        |-> (o_jump.taken && o_jump.target == i_rd_a && o_jump.reg_use == 2'b10))
        else begin
            $error("register jump target wrong");
            fail_count++;
        end

    a_branch: assert property (@(posedge i_clk) disable iff (i_reset)
        (op == `MIPS_OP_BEQ || op == `MIPS_OP_BNE)
        |-> (o_jump.taken == ((i_rd_a == i_rd_b) ^ (op == `MIPS_OP_BNE))
             && o_jump.reg_use == 2'b01))
        else begin
            $error("branch decision wrong");
            fail_count++;
        end

    a_halt_flag: assert property (@(posedge i_clk)
        o_halt == (i_instr == `MIPS_HALT_WORD))
        else begin
            $error("halt flag wrong");
            fail_count++;
        end

endmodule

bind instruction_decode instruction_decode_asserts u_asserts (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_instr (i_instr),
    .i_pc    (i_pc),
    .i_stall (i_stall),
    .i_halt  (i_halt),
    .o_ctl   (o_ctl),
    .o_ex    (o_ex),
    .o_jump  (o_jump),
    .o_halt  (o_halt),
    .i_rd_a  (rd_a),
    .i_rd_b  (rd_b)
);

`default_nettype wire

//--- tb_instruction_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_id_config.svh"

module tb_instruction_decode
    import mips_id_pkg::*;
;

    logic        i_clk = 1'b0;
    logic        i_reset;
    instr_t      i_instr;
    logic [31:0] i_pc;
    logic        i_wb_write;
    logic [4:0]  i_wb_addr;
    logic [31:0] i_wb_data;
    logic        i_stall;
    logic        i_halt;
    id_ctl_t     o_ctl;
    id_ex_t      o_ex;
    jump_t       o_jump;
    logic        o_halt;

    int          seed = 14849;
    logic [31:0] shadow [32];
    int          errors = 0;
    int          test_start = 0;
    int          tests = 0;
    id_ctl_t     held_ctl;
    id_ex_t      held_ex;
    logic [31:0] words [17];

    always #20 i_clk = ~i_clk;

    instruction_decode u_dut (.*);

    function automatic logic [31:0] rtype(input int rs, input int rt, input int rd,
                                          input logic [5:0] fn);
        return {6'b0, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        int total;
        total = errors + u_dut.u_asserts.fail_count;
        tests++;
        $display("test %0d %s: %0d errors", tests, name, total - test_start);
        test_start = total;
    endtask

    // drive on the falling edge and check the combinational halt flag
    task automatic present(input logic [31:0] word, input logic [31:0] pc);
        @(negedge i_clk);
        i_instr = word;
        i_pc    = pc;
        #5;
        check_value("o_halt", {31'd0, word == `MIPS_HALT_WORD}, {31'd0, o_halt});
    endtask

    task automatic check_operands(input logic [31:0] ra, input logic [31:0] rb);
        @(negedge i_clk);
        check_value("o_ex.ra", ra, o_ex.ra);
        check_value("o_ex.rb", rb, o_ex.rb);
    endtask

    task automatic check_jump(input logic taken, input logic [31:0] target);
        check_value("o_jump.taken", {31'd0, taken}, {31'd0, o_jump.taken});
        if (taken) check_value("o_jump.target", target, o_jump.target);
    endtask

    initial begin
        for (int c = 0; c < 4000; c++) @(posedge i_clk);
        $display("timeout: the test sequence did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        i_reset    = 1'b1;
        i_instr    = '0;
        i_pc       = '0;
        i_wb_write = 1'b0;
        i_wb_addr  = '0;
        i_wb_data  = '0;
        i_stall    = 1'b0;
        i_halt     = 1'b0;
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;

        check_value("o_ctl", 32'd0, {21'd0, o_ctl});
        check_value("o_ex.ra", 32'd0, o_ex.ra);
        check_value("o_ex.rb", 32'd0, o_ex.rb);
        check_value("o_ex.imm", 32'd0, o_ex.imm);
        check_value("o_ex fields", 32'd0, o_ex[31:0]);
        for (int r = 0; r < 32; r++) begin
            present(rtype(r, 31 - r, 1, 6'h20), 32'h100);
            check_operands(32'd0, 32'd0);
        end
        report_test("reset");

        shadow[0] = 32'd0;
        for (int r = 0; r < 32; r++) begin
            @(negedge i_clk);
            i_wb_write = 1'b1;
            i_wb_addr  = 5'(r);
            i_wb_data  = $random(seed);
            if (r != 0) shadow[r] = i_wb_data; // r0 stays zero
        end
        @(negedge i_clk);
        i_wb_write = 1'b0;
        for (int r = 0; r < 32; r++) begin
            present(rtype(r, (r * 7) % 32, 2, 6'h21), 32'h104);
            check_operands(shadow[r], shadow[(r * 7) % 32]);
        end
        report_test("register write and read");

        words = '{rtype(1, 2, 3, 6'h20), rtype(4, 0, 0, `MIPS_FN_JR),
                  rtype(4, 0, 31, `MIPS_FN_JALR), itype(6'h20, 1, 2, 16'h4),
                  itype(6'h21, 1, 2, 16'h8), itype(6'h23, 1, 2, 16'hc),
                  itype(6'h24, 1, 2, 16'h1), itype(6'h25, 1, 2, 16'h2),
                  itype(6'h28, 1, 2, 16'h4), itype(6'h29, 1, 2, 16'h4),
                  itype(6'h2b, 1, 2, 16'h4), itype(6'h08, 1, 2, 16'hfff0),
                  itype(6'h0d, 1, 2, 16'h00ff), itype(`MIPS_OP_BEQ, 1, 2, 16'h3),
                  itype(`MIPS_OP_BNE, 1, 2, 16'h3), {`MIPS_OP_JAL, 26'h12345},
                  {`MIPS_OP_J, 26'h54321}};
        for (int k = 0; k < 17; k++) begin
            present(words[k], 32'h200 + 32'(k * 4));
        end
        @(negedge i_clk);
        report_test("control decode");

        @(negedge i_clk);
        i_stall = 1'b1;
        present(rtype(3, 4, 5, 6'h20), 32'h300);
        @(negedge i_clk);
        i_stall = 1'b0;
        check_value("o_ctl", 32'd0, {21'd0, o_ctl});
        check_value("o_ex.rs", 32'd3, {27'd0, o_ex.rs});
        present(`MIPS_NOP_WORD, 32'h304);
        @(negedge i_clk);
        check_value("o_ctl", 32'd0, {21'd0, o_ctl});
        check_value("o_ex.rd", 32'd0, {27'd0, o_ex.rd});
        present(itype(6'h23, 6, 7, 16'h10), 32'h308);
        @(negedge i_clk);
        held_ctl = o_ctl;
        held_ex  = o_ex;
        i_halt   = 1'b1;
        for (int k = 0; k < 4; k++) begin
            present(rtype(k + 8, k + 9, k + 10, 6'h22), 32'h310);
        end
        @(negedge i_clk);
        check_value("o_ctl", {21'd0, held_ctl}, {21'd0, o_ctl});
        check_value("o_ex.imm", held_ex.imm, o_ex.imm);
        check_value("o_ex.ra", held_ex.ra, o_ex.ra);
        i_halt = 1'b0;
        report_test("bubble and freeze");

        present(itype(`MIPS_OP_BEQ, 7, 7, 16'h0010), 32'h400);
        check_jump(1'b1, 32'h400 + 32'd4 + 32'h40);
        present(itype(`MIPS_OP_BEQ, 0, 0, 16'hfffc), 32'h400);
        check_jump(1'b1, 32'h400 + 32'd4 - 32'h10);
        present(itype(`MIPS_OP_BEQ, 1, 2, 16'hfffc), 32'h400);
        check_jump(shadow[1] == shadow[2], 32'h400 + 32'd4 - 32'h10);
        present(itype(`MIPS_OP_BNE, 7, 7, 16'h0010), 32'h400);
        check_jump(1'b0, 32'd0);
        present(itype(`MIPS_OP_BNE, 1, 2, 16'h0020), 32'h400);
        check_jump(shadow[1] != shadow[2], 32'h400 + 32'd4 + 32'h80);
        present({`MIPS_OP_J, 26'h2abcdef}, 32'ha000_1000);
        check_jump(1'b1, {4'ha, 26'h2abcdef, 2'b00});
        present(rtype(9, 0, 0, `MIPS_FN_JR), 32'h500);
        check_jump(1'b1, shadow[9]);
        present({`MIPS_OP_JAL, 26'h01f1234}, 32'h6000_0040); // rt and rd bits set
        check_jump(1'b1, {4'h6, 26'h01f1234, 2'b00});
        check_operands(32'h6000_0040, 32'd4);
        check_value("o_ex.rd", 32'd31, {27'd0, o_ex.rd});
        check_value("o_ex.rt", 32'd0, {27'd0, o_ex.rt});
        present(rtype(9, 5, 31, `MIPS_FN_JALR), 32'h700);
        check_jump(1'b1, shadow[9]);
        check_operands(32'h700, 32'd4);
        check_value("o_ex.rt", 32'd0, {27'd0, o_ex.rt});
        report_test("jumps and branches");

        present(`MIPS_HALT_WORD, 32'h800);
        present(32'hffff_fffe, 32'h804);
        present(`MIPS_NOP_WORD, 32'h808);
        @(negedge i_clk);
        report_test("halt instruction");

        $display("%0d tests, %0d check errors, %0d assertion failures",
                 tests, errors, u_dut.u_asserts.fail_count);
        if (errors == 0 && u_dut.u_asserts.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
mips_id_pkg.sv
id_control_unit.sv
register_bank.sv
branch_resolver.sv
operand_select.sv
instruction_decode.sv
instruction_decode_asserts.sv
tb_instruction_decode.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
rm -f sim.log
( verilator --binary --assert -j 0 --top-module tb_instruction_decode -f files.f \
    -o sim_tb && ./obj_dir/sim_tb +verilator+error+limit+1000 ) 2>&1 | tee sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && echo "simulation reported failure" && exit 1
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "build or run did not complete"; exit 1; }
exit 0
